// ==== list.f ====
+incdir+src
+incdir+verification
src/arcade_ctrl_pkg.sv
src/game_config.sv
src/reset_gen.sv
src/ps2_key_decoder.sv
src/input_port_mapper.sv
src/arcade_ctrl_top.sv
verification/tb_arcade_ctrl.sv

// ==== Bender.yml ====
package:
  name: arcade_ctrl

sources:
  - include_dirs:
      - src
    files:
      - src/arcade_ctrl_pkg.sv
      - src/game_config.sv
      - src/reset_gen.sv
      - src/ps2_key_decoder.sv
      - src/input_port_mapper.sv
      - src/arcade_ctrl_top.sv
  - target: test
    include_dirs:
      - src
      - verification
    files:
      - verification/tb_arcade_ctrl.sv

// ==== verification/tb_arcade_ctrl_table.svh ====
`ifndef TB_ARCADE_CTRL_TABLE_SVH
`define TB_ARCADE_CTRL_TABLE_SVH

// Columns: game byte, joy1, joy2, expected in0, in1, in2
// Rows assume no keys held and the DIP bank at its reset value
localparam int PORT_ROWS = 10;

logic [95:0] port_table [PORT_ROWS];

task automatic load_port_table();
	port_table[0] = {8'h00, 32'h0000_0000, 32'h0000_0000, 8'h7f, 8'hff, 8'hff};
	port_table[1] = {8'h00, 32'h0000_0011, 32'h0000_0000, 8'h7f, 8'hee, 8'hee};
	port_table[2] = {8'h00, 32'h0000_0000, 32'h0000_1c0c, 8'h72, 8'hf3, 8'hf3};
	port_table[3] = {8'h01, 32'h0000_0021, 32'h0000_0012, 8'h7f, 8'hee, 8'hdd};
	port_table[4] = {8'h01, 32'h0000_040c, 32'h0000_00c0, 8'h7b, 8'hf3, 8'hff};
	port_table[5] = {8'h02, 32'h0000_0400, 32'h0000_0000, 8'h7a, 8'hff, 8'hff}; // Start as coin
	port_table[6] = {8'h02, 32'h0000_00e1, 32'h0000_0016, 8'h6f, 8'hff, 8'h84};
	port_table[7] = {8'h03, 32'h0000_000a, 32'h0000_1010, 8'h6e, 8'hfa, 8'hea};
	port_table[8] = {8'h03, 32'h0000_0805, 32'h0000_0000, 8'h77, 8'hf5, 8'hf5};
	port_table[9] = {8'h04, 32'h0000_1fff, 32'h0000_0000, 8'hff, 8'hff, 8'hff}; // Unknown game
endtask

`endif

// ==== verification/tb_arcade_ctrl.sv ====
`timescale 1ns/100ps
`include "arcade_ctrl_params.svh"

module tb_arcade_ctrl;
	import arcade_ctrl_pkg::*;

	`include "tb_arcade_ctrl_table.svh"

	localparam int HOLD        = 1 << `RESET_HOLD_BITS;
	localparam int TEST_CYCLES = 3 * HOLD + 8 * PORT_ROWS + 2 * (2 * 23 + 4) * 2 + 8 * 5 + 64;
	localparam int MAX_CYCLES  = TEST_CYCLES + TEST_CYCLES / 4;

	// Key codes in the order of the expected key vector {sys, p2, p1}
	localparam logic [22:0][7:0] KEY_CODES = {
		`KEY_6, `KEY_5, `KEY_ESC, `KEY_2, `KEY_F2, `KEY_1, `KEY_F1,
		`KEY_W, `KEY_Q, `KEY_S, `KEY_A, `KEY_R, `KEY_F, `KEY_D, `KEY_G,
		`KEY_LSHIFT, `KEY_SPACE, `KEY_LALT, `KEY_LCTRL,
		`KEY_UP, `KEY_DOWN, `KEY_LEFT, `KEY_RIGHT
	};

	logic        clk_sys;
	logic        rst_n;
	dl_bus_t     dl;
	ps2_event_t  ps2_key;
	joy_word_t   joy1;
	joy_word_t   joy2;
	logic        status_reset;
	logic        osd_reset;
	logic        aspect_wide;
	logic        orient_horz;
	logic        game_rst;
	in_ports_t   in_ports;
	logic [7:0]  hdmi_arx;
	logic [7:0]  hdmi_ary;

	logic [19:0] exp_keys;    // Held keys as {sys, p2, p1}
	logic [7:0]  exp_dip0;
	logic        exp_service;
	logic [7:0]  exp_arx;
	logic [7:0]  exp_ary;
	logic [7:0]  cur_game;
	logic [31:0] lcg_state;
	int          cycle_count;
	int          wait_cycles;
	logic [7:0]  row_game;
	joy_word_t   row_j1;
	joy_word_t   row_j2;
	logic [7:0]  row_in0;
	logic [7:0]  row_in1;
	logic [7:0]  row_in2;
	joy_word_t   rnd_j1;
	joy_word_t   rnd_j2;

	arcade_ctrl_top i_arcade_ctrl_top (
		.clk_sys      (clk_sys),
		.rst_n        (rst_n),
		.dl           (dl),
		.ps2_key      (ps2_key),
		.joy1         (joy1),
		.joy2         (joy2),
		.status_reset (status_reset),
		.osd_reset    (osd_reset),
		.aspect_wide  (aspect_wide),
		.orient_horz  (orient_horz),
		.game_rst     (game_rst),
		.in_ports     (in_ports),
		.hdmi_arx     (hdmi_arx),
		.hdmi_ary     (hdmi_ary)
	);

	always #2 clk_sys = ~clk_sys;

	always @(posedge clk_sys) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= MAX_CYCLES)
			report_failure("Timeout, the tests did not finish within the cycle limit");
	end

	// ============================================================
	// Helpers
	// ============================================================
	task automatic report_failure(input string msg);
		$display("%s", msg);
		$display("Simulation failed");
		$fatal(1, "Stopped at %0t ns", $time);
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
	                           input logic [31:0] expected);
		if (got !== expected)
			report_failure($sformatf("Fail at %0t ns: %s is %h, expected %h",
			                         $time, name, got, expected));
	endtask

	task automatic check_ports(input in_ports_t expected);
		check_value("in_ports.in0", in_ports.in0, expected.in0);
		check_value("in_ports.in1", in_ports.in1, expected.in1);
		check_value("in_ports.in2", in_ports.in2, expected.in2);
		check_value("in_ports.in3", in_ports.in3, expected.in3);
	endtask

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state ^ (lcg_state >> 16); // Low bits alone repeat too soon
	endfunction

	// Port bytes built active high from the game layouts and then inverted
	function automatic in_ports_t expected_ports(input logic [7:0] game_byte,
	                                             input joy_word_t j1, input joy_word_t j2);
		player_btn_t a;
		player_btn_t b;
		player_btn_t c;
		sys_btn_t    ks;
		logic        s1;
		logic        s2;
		logic        cn;
		logic [7:0]  h0;
		logic [7:0]  h1;
		logic [7:0]  h2;
		in_ports_t   r;
		a  = exp_keys[7:0] | j1.btn;
		b  = exp_keys[15:8] | j2.btn;
		c  = a | b;
		ks = exp_keys[19:16];
		s1 = ks.start1 | j1.start1 | j2.start1;
		s2 = ks.start2 | j1.start2 | j2.start2;
		cn = ks.coin1 | ks.coin2 | j1.coin | j2.coin;
		h0 = 8'h00;
		h1 = 8'h00;
		h2 = 8'h00;
		h0[7] = exp_service;
		h0[3] = s2;
		h0[2] = s1;
		h0[0] = cn;
		case (game_byte)
			8'd0: begin
				h1[4:0] = {c.fire_a, c.up, c.down, c.left, c.right};
				h2 = h1;
			end
			8'd1: begin
				h1[5:0] = {a.fire_a, a.fire_b, a.up, a.down, a.left, a.right};
				h2[5:0] = {b.fire_a, b.fire_b, b.up, b.down, b.left, b.right};
			end
			8'd2: begin
				h0[4] = c.fire_a;
				h0[0] = cn | s1 | s2;
				h2[6:0] = {c.fire_b, c.fire_c, c.fire_d, c.down, c.up, c.right, c.left};
			end
			8'd3: begin
				h0[4] = c.fire_a;
				h1[3:0] = {c.down, c.up, c.right, c.left};
				h2[4:0] = {c.fire_a, c.down, c.up, c.right, c.left};
			end
			default: h0 = 8'h00; // No game selected so the ports stay idle
		endcase
		r.in0 = ~h0;
		r.in1 = ~h1;
		r.in2 = ~h2;
		r.in3 = exp_dip0;
		return r;
	endfunction

	task automatic dl_write_byte(input logic [7:0] index, input logic [`DL_ADDR_W-1:0] addr,
	                             input logic [7:0] data);
		@(posedge clk_sys);
		dl.download <= 1'b1;
		dl.wr       <= 1'b1;
		dl.index    <= index;
		dl.addr     <= addr;
		dl.data     <= data;
		@(posedge clk_sys);
		dl.wr <= 1'b0;
		@(negedge clk_sys);
	endtask

	task automatic dl_finish();
		@(posedge clk_sys);
		dl.download <= 1'b0;
		dl.wr       <= 1'b0;
	endtask

	task automatic select_game(input logic [7:0] game_byte);
		dl_write_byte(`IDX_GAME, '0, game_byte);
		dl_finish();
		@(negedge clk_sys); // Decode stage has settled
		cur_game = game_byte;
	endtask

	task automatic key_event(input logic [7:0] code, input logic pressed);
		@(posedge clk_sys);
		ps2_key.toggle   <= ~ps2_key.toggle;
		ps2_key.pressed  <= pressed;
		ps2_key.extended <= 1'b0;
		ps2_key.code     <= code;
		@(posedge clk_sys);
		@(negedge clk_sys);
	endtask

	// ============================================================
	// Test sequence
	// ============================================================
	initial begin
		clk_sys      = 1'b0;
		rst_n        = 1'b0;
		dl           = '0;
		ps2_key      = '0;
		joy1         = '0;
		joy2         = '0;
		status_reset = 1'b0;
		osd_reset    = 1'b0;
		aspect_wide  = 1'b0;
		orient_horz  = 1'b0;
		cycle_count  = 0;
		lcg_state    = 32'd33;
		exp_keys     = '0;
		exp_dip0     = 8'hff;
		exp_service  = 1'b1;
		cur_game     = 8'd0;
		load_port_table();
		repeat (2) @(posedge clk_sys);
		rst_n <= 1'b1;
		@(negedge clk_sys);
		check_value("game_rst", game_rst, 1);

		// ROM download holds the game in reset
		for (int i = 0; i < 6; i++) begin
			dl_write_byte(`IDX_ROM, i, 8'(i * 37));
			check_value("game_rst", game_rst, 1);
		end
		dl_finish();
		wait_cycles = 0;
		while (game_rst !== 1'b0) begin
			@(negedge clk_sys);
			wait_cycles++;
			if (wait_cycles > 8)
				report_failure("game_rst stayed high after the ROM download ended");
		end
		wait_cycles = 0;
		while (game_rst === 1'b0) begin
			@(negedge clk_sys);
			wait_cycles++;
			if (wait_cycles > HOLD + 8)
				report_failure("No second game_rst pulse after the hold time");
		end
		if (wait_cycles < HOLD - 3 || wait_cycles > HOLD + 1)
			report_failure($sformatf("Second game_rst pulse came %0d cycles after release",
			                         wait_cycles));
		repeat (HOLD + 8) begin // The pulse must not repeat
			@(negedge clk_sys);
			check_value("game_rst", game_rst, 0);
		end

		// status_reset first and osd_reset second
		for (int r = 0; r < 2; r++) begin
			@(posedge clk_sys);
			status_reset <= (r == 0);
			osd_reset    <= (r == 1);
			repeat (3) begin
				@(posedge clk_sys);
				@(negedge clk_sys);
				check_value("game_rst", game_rst, 1);
			end
			@(posedge clk_sys);
			status_reset <= 1'b0;
			osd_reset    <= 1'b0;
			@(posedge clk_sys);
			@(negedge clk_sys);
			check_value("game_rst", game_rst, 0);
		end

		// ============================================================
		// Port mapping from the table and from random joysticks
		// ============================================================
		for (int r = 0; r < PORT_ROWS; r++) begin
			{row_game, row_j1, row_j2, row_in0, row_in1, row_in2} = port_table[r];
			select_game(row_game);
			@(posedge clk_sys);
			joy1 <= row_j1;
			joy2 <= row_j2;
			@(negedge clk_sys);
			check_value("in_ports.in0", in_ports.in0, row_in0);
			check_value("in_ports.in1", in_ports.in1, row_in1);
			check_value("in_ports.in2", in_ports.in2, row_in2);
			repeat (3) begin
				rnd_j1 = lcg_next();
				rnd_j2 = lcg_next();
				@(posedge clk_sys);
				joy1 <= rnd_j1;
				joy2 <= rnd_j2;
				@(negedge clk_sys);
				check_ports(expected_ports(row_game, rnd_j1, rnd_j2));
			end
		end
		@(posedge clk_sys);
		joy1 <= '0;
		joy2 <= '0;

		// HDMI aspect for each game and switch setting with byte 7 as an unknown game
		for (int g = 0; g < 5; g++) begin
			select_game((g == 4) ? 8'd7 : 8'(g));
			for (int m = 0; m < 4; m++) begin
				@(posedge clk_sys);
				aspect_wide <= m[1];
				orient_horz <= m[0];
				@(negedge clk_sys);
				if (m[1]) begin
					exp_arx = `ARX_WIDE;
					exp_ary = `ARY_WIDE;
				end else if (m[0] || g != 3) begin
					exp_arx = `ARX_LAND;
					exp_ary = `ARY_LAND;
				end else begin
					exp_arx = `ARX_PORT;
					exp_ary = `ARY_PORT;
				end
				check_value("hdmi_arx", hdmi_arx, exp_arx);
				check_value("hdmi_ary", hdmi_ary, exp_ary);
			end
		end

		// Keyboard press and release of each key in Timber and Discs of Tron
		for (int g = 1; g < 3; g++) begin
			select_game(8'(g));
			for (int k = 0; k < 23; k++) begin
				for (int p = 1; p >= 0; p--) begin
					key_event(KEY_CODES[k], p[0]);
					exp_keys[(k < 16) ? k : 16 + (k - 16) / 2] = p[0];
					check_ports(expected_ports(cur_game, '0, '0));
				end
			end
			key_event(8'h5a, 1'b1); // Enter is not mapped
			check_ports(expected_ports(cur_game, '0, '0));
			key_event(8'h00, 1'b1);
			check_ports(expected_ports(cur_game, '0, '0));
		end

		// DIP bank writes where address 8 lies outside the bank
		dl_write_byte(`IDX_DIP, 0, 8'h5a);
		exp_dip0 = 8'h5a;
		check_ports(expected_ports(cur_game, '0, '0));
		dl_write_byte(`IDX_DIP, 1, 8'hfe);
		exp_service = 1'b0;
		check_ports(expected_ports(cur_game, '0, '0));
		dl_write_byte(`IDX_DIP, 8, 8'h00);
		check_ports(expected_ports(cur_game, '0, '0));
		dl_finish();

		$display("Simulation passed");
		$finish;
	end

endmodule

// ==== src/arcade_ctrl_top.sv ====
`timescale 1ns/100ps
`include "arcade_ctrl_params.svh"

module arcade_ctrl_top (
	input  logic                       clk_sys,
	input  logic                       rst_n,
	input  arcade_ctrl_pkg::dl_bus_t    dl,
	input  arcade_ctrl_pkg::ps2_event_t ps2_key,
	input  arcade_ctrl_pkg::joy_word_t  joy1,
	input  arcade_ctrl_pkg::joy_word_t  joy2,
	input  logic                       status_reset,
	input  logic                       osd_reset,
	input  logic                       aspect_wide,
	input  logic                       orient_horz,
	output logic                       game_rst,
	output arcade_ctrl_pkg::in_ports_t  in_ports,
	output logic [7:0]                 hdmi_arx,
	output logic [7:0]                 hdmi_ary
);
	import arcade_ctrl_pkg::*;

	player_btn_t key_p1;
	player_btn_t key_p2;
	sys_btn_t    key_sys;
	game_t       game;
	logic        game_valid;
	logic [7:0]  dip0;
	logic        service;

	// ============================================================
	// Configuration and reset
	// ============================================================
	game_config i_game_config (
		.clk_sys     (clk_sys),
		.rst_n       (rst_n),
		.dl          (dl),
		.aspect_wide (aspect_wide),
		.orient_horz (orient_horz),
		.game        (game),
		.game_valid  (game_valid),
		.dip0        (dip0),
		.service     (service),
		.hdmi_arx    (hdmi_arx),
		.hdmi_ary    (hdmi_ary)
	);

	reset_gen #(
		.HOLD_BITS (`RESET_HOLD_BITS)
	) i_reset_gen (
		.clk_sys      (clk_sys),
		.rst_n        (rst_n),
		.dl           (dl),
		.status_reset (status_reset),
		.osd_reset    (osd_reset),
		.game_rst     (game_rst)
	);

	// ============================================================
	// Controls
	// ============================================================
	ps2_key_decoder i_ps2_key_decoder (
		.clk_sys (clk_sys),
		.rst_n   (rst_n),
		.ps2_key (ps2_key),
		.key_p1  (key_p1),
		.key_p2  (key_p2),
		.key_sys (key_sys)
	);

	input_port_mapper i_input_port_mapper (
		.key_p1     (key_p1),
		.key_p2     (key_p2),
		.key_sys    (key_sys),
		.joy1       (joy1),
		.joy2       (joy2),
		.game       (game),
		.game_valid (game_valid),
		.dip0       (dip0),
		.service    (service),
		.in_ports   (in_ports)
	);

endmodule

// ==== src/input_port_mapper.sv ====
`timescale 1ns/100ps

module input_port_mapper (
	input  arcade_ctrl_pkg::player_btn_t key_p1,
	input  arcade_ctrl_pkg::player_btn_t key_p2,
	input  arcade_ctrl_pkg::sys_btn_t    key_sys,
	input  arcade_ctrl_pkg::joy_word_t   joy1,
	input  arcade_ctrl_pkg::joy_word_t   joy2,
	input  arcade_ctrl_pkg::game_t       game,
	input  logic                         game_valid,
	input  logic [7:0]                   dip0,
	input  logic                         service,
	output arcade_ctrl_pkg::in_ports_t   in_ports
);
	import arcade_ctrl_pkg::*;

	player_btn_t p1;
	player_btn_t p2;
	player_btn_t all;
	logic        start1;
	logic        start2;
	logic        coin;
	logic        is_dotron;

	// ============================================================
	// Merge keyboard and joysticks
	// ============================================================
	assign p1  = player_btn_t'(key_p1 | joy1.btn);
	assign p2  = player_btn_t'(key_p2 | joy2.btn);
	assign all = player_btn_t'(p1 | p2);

	assign is_dotron = game_valid && (game == game_dotron);

	assign start1 = key_sys.start1 | joy1.start1 | joy2.start1;
	assign start2 = key_sys.start2 | joy1.start2 | joy2.start2;
	assign coin   = key_sys.coin1 | key_sys.coin2 | joy1.coin | joy2.coin
	                | (is_dotron & (start1 | start2)); // Start doubles as coin

	// ============================================================
	// Per-game port layout, active low
	// ============================================================
	always_comb begin
		in_ports     = '1;
		in_ports.in3 = dip0;
		if (game_valid) begin
			case (game)
				game_tapper: begin
					in_ports.in0 = ~{service, 3'b000, start2, start1, 1'b0, coin};
					in_ports.in1 = ~{3'b000, all.fire_a, all.up, all.down, all.left, all.right};
					in_ports.in2 = ~{3'b000, all.fire_a, all.up, all.down, all.left, all.right};
				end
				game_timber: begin
					in_ports.in0 = ~{service, 3'b000, start2, start1, 1'b0, coin};
					in_ports.in1 = ~{2'b00, p1.fire_a, p1.fire_b,
					                 p1.up, p1.down, p1.left, p1.right};
					in_ports.in2 = ~{2'b00, p2.fire_a, p2.fire_b,
					                 p2.up, p2.down, p2.left, p2.right};
				end
				game_dotron: begin
					in_ports.in0 = ~{service, 2'b00, all.fire_a, start2, start1, 1'b0, coin};
					in_ports.in1 = 8'hff; // Spinner port, idle
					in_ports.in2 = ~{1'b0, all.fire_b, all.fire_c, all.fire_d,
					                 all.down, all.up, all.right, all.left};
				end
				game_journey: begin
					in_ports.in0 = ~{service, 2'b00, all.fire_a, start2, start1, 1'b0, coin};
					in_ports.in1 = ~{4'b0000, all.down, all.up, all.right, all.left};
					in_ports.in2 = ~{3'b000, all.fire_a, all.down, all.up, all.right, all.left};
				end
				default: ;
			endcase
		end
	end

endmodule

// ==== src/ps2_key_decoder.sv ====
`timescale 1ns/100ps
`include "arcade_ctrl_params.svh"

module ps2_key_decoder (
	input  logic                        clk_sys,
	input  logic                        rst_n,
	input  arcade_ctrl_pkg::ps2_event_t ps2_key,
	output arcade_ctrl_pkg::player_btn_t key_p1,
	output arcade_ctrl_pkg::player_btn_t key_p2,
	output arcade_ctrl_pkg::sys_btn_t    key_sys
);
	import arcade_ctrl_pkg::*;

	logic toggle_d;
	logic new_event;
	logic pressed;

	assign new_event = (ps2_key.toggle != toggle_d);
	assign pressed   = ps2_key.pressed;

	// ============================================================
	// Held button state per key
	// ============================================================
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			toggle_d <= 1'b0;
			key_p1   <= '0;
			key_p2   <= '0;
			key_sys  <= '0;
		end else begin
			toggle_d <= ps2_key.toggle;
			if (new_event) begin
				case (ps2_key.code)
					// Player 1
					`KEY_RIGHT:  key_p1.right  <= pressed;
					`KEY_LEFT:   key_p1.left   <= pressed;
					`KEY_DOWN:   key_p1.down   <= pressed;
					`KEY_UP:     key_p1.up     <= pressed;
					`KEY_LCTRL:  key_p1.fire_a <= pressed;
					`KEY_LALT:   key_p1.fire_b <= pressed;
					`KEY_SPACE:  key_p1.fire_c <= pressed;
					`KEY_LSHIFT: key_p1.fire_d <= pressed;

					// Player 2, MAME layout
					`KEY_G: key_p2.right  <= pressed;
					`KEY_D: key_p2.left   <= pressed;
					`KEY_F: key_p2.down   <= pressed;
					`KEY_R: key_p2.up     <= pressed;
					`KEY_A: key_p2.fire_a <= pressed;
					`KEY_S: key_p2.fire_b <= pressed;
					`KEY_Q: key_p2.fire_c <= pressed;
					`KEY_W: key_p2.fire_d <= pressed;

					// Starts and coins
					`KEY_F1, `KEY_1: key_sys.start1 <= pressed;
					`KEY_F2, `KEY_2: key_sys.start2 <= pressed;
					`KEY_ESC, `KEY_5: key_sys.coin1 <= pressed;
					`KEY_6:           key_sys.coin2 <= pressed;

					default: ; // Other keys ignored
				endcase
			end
		end
	end

endmodule

// ==== src/reset_gen.sv ====
`timescale 1ns/100ps
`include "arcade_ctrl_params.svh"

module reset_gen #(
	parameter int HOLD_BITS = `RESET_HOLD_BITS
) (
	input  logic                     clk_sys,
	input  logic                     rst_n,
	input  arcade_ctrl_pkg::dl_bus_t dl,
	input  logic                     status_reset,
	input  logic                     osd_reset,
	output logic                     game_rst
);
	import arcade_ctrl_pkg::*;

	logic                 rom_dl;
	logic                 rom_dl_d;
	logic                 rom_loaded;
	logic                 rst_req;
	logic [HOLD_BITS-1:0] hold_cnt;

	assign rom_dl  = dl.download && (dl.index == `IDX_ROM);
	assign rst_req = status_reset | osd_reset;

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			rom_dl_d   <= 1'b0;
			rom_loaded <= 1'b0;
			hold_cnt   <= '1;
			game_rst   <= 1'b1;
		end else begin
			rom_dl_d <= rom_dl;
			if (rom_dl_d & ~rom_dl) rom_loaded <= 1'b1; // Download just ended

			// Second reset pulse after the hold time
			if (rst_req | ~rom_loaded)
				hold_cnt <= '1;
			else if (hold_cnt != '0)
				hold_cnt <= hold_cnt - 1'b1;

			game_rst <= rst_req | rom_dl | ~rom_loaded
			            | (hold_cnt == HOLD_BITS'(1));
		end
	end

endmodule

// ==== src/game_config.sv ====
`timescale 1ns/100ps
`include "arcade_ctrl_params.svh"

module game_config (
	input  logic                     clk_sys,
	input  logic                     rst_n,
	input  arcade_ctrl_pkg::dl_bus_t dl,
	input  logic                     aspect_wide,
	input  logic                     orient_horz,
	output arcade_ctrl_pkg::game_t   game,
	output logic                     game_valid,  // Low when the select byte is above 3
	output logic [7:0]               dip0,
	output logic                     service,
	output logic [7:0]               hdmi_arx,
	output logic [7:0]               hdmi_ary
);
	import arcade_ctrl_pkg::*;

	localparam int DIP_AW = $clog2(`DIP_BYTES);

	logic [7:0] game_byte;
	logic [7:0] dip_sw [`DIP_BYTES];
	logic       game_wr;
	logic       dip_wr;
	logic       landscape;

	assign game_wr = dl.download & dl.wr & (dl.index == `IDX_GAME);
	assign dip_wr  = dl.download & dl.wr & (dl.index == `IDX_DIP) & (dl.addr < `DIP_BYTES);

	// ============================================================
	// Game select
	// ============================================================
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			game_byte <= 8'd0;
		end else if (game_wr) begin
			game_byte <= dl.data; // Last write wins
		end
	end

	// Decode stage, one cycle behind the byte
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			game       <= game_tapper;
			game_valid <= 1'b1;
		end else begin
			game       <= game_t'(game_byte[1:0]);
			game_valid <= (game_byte < 8'd4);
		end
	end

	// DIP bank, comes up all ones
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < `DIP_BYTES; i++) begin
				dip_sw[i] <= 8'hff;
			end
		end else if (dip_wr) begin
			dip_sw[dl.addr[DIP_AW-1:0]] <= dl.data;
		end
	end

	assign dip0    = dip_sw[0];
	assign service = dip_sw[1][0];

	// Journey is the only vertical monitor game
	assign landscape = !(game_valid && (game == game_journey));

	assign hdmi_arx = aspect_wide ? `ARX_WIDE :
	                  (orient_horz | landscape) ? `ARX_LAND : `ARX_PORT;
	assign hdmi_ary = aspect_wide ? `ARY_WIDE :
	                  (orient_horz | landscape) ? `ARY_LAND : `ARY_PORT;

endmodule

// ==== src/arcade_ctrl_pkg.sv ====
`include "arcade_ctrl_params.svh"

package arcade_ctrl_pkg;

	// Game select byte values 0..3
	typedef enum logic [1:0] {
		game_tapper  = 2'd0,
		game_timber  = 2'd1,
		game_dotron  = 2'd2,
		game_journey = 2'd3
	} game_t;

	// ============================================================
	// Download bus from the host, 43 bits
	// ============================================================
	typedef struct packed {
		logic                  download; // Level for the whole transfer
		logic                  wr;       // One cycle per byte
		logic [7:0]            index;
		logic [`DL_ADDR_W-1:0] addr;
		logic [7:0]            data;
	} dl_bus_t;

	// One PS/2 key event, 11 bits
	typedef struct packed {
		logic       toggle;   // Flips on every new event
		logic       pressed;
		logic       extended;
		logic [7:0] code;
	} ps2_event_t;

	// Bit order matches the low byte of a joystick word
	typedef struct packed {
		logic fire_d;
		logic fire_c;
		logic fire_b;
		logic fire_a;
		logic up;
		logic down;
		logic left;
		logic right;
	} player_btn_t;

	typedef struct packed {
		logic coin2;
		logic coin1;
		logic start2;
		logic start1;
	} sys_btn_t;

	typedef struct packed {
		logic [18:0] unused;
		logic        coin;
		logic        start2;
		logic        start1;
		logic [1:0]  rotate;  // Not carried
		player_btn_t btn;
	} joy_word_t;

	// Active-low game input ports
	typedef struct packed {
		logic [7:0] in3;
		logic [7:0] in2;
		logic [7:0] in1;
		logic [7:0] in0;
	} in_ports_t;

endpackage

// ==== src/arcade_ctrl_params.svh ====
`ifndef ARCADE_CTRL_PARAMS_SVH
`define ARCADE_CTRL_PARAMS_SVH

// ============================================================
// Download bus
// ============================================================
`define IDX_ROM          8'd0
`define IDX_GAME         8'd1
`define IDX_DIP          8'd254
`define DL_ADDR_W        25
`define DIP_BYTES        8
`define RESET_HOLD_BITS  8

// ============================================================
// PS/2 set-2 make codes
// ============================================================
`define KEY_UP      8'h75 // Arrow keys, sent with E0 prefix
`define KEY_DOWN    8'h72
`define KEY_LEFT    8'h6b
`define KEY_RIGHT   8'h74
`define KEY_LCTRL   8'h14
`define KEY_LALT    8'h11
`define KEY_SPACE   8'h29
`define KEY_LSHIFT  8'h12
`define KEY_R       8'h2d
`define KEY_F       8'h2b
`define KEY_D       8'h23
`define KEY_G       8'h34
`define KEY_A       8'h1c
`define KEY_S       8'h1b
`define KEY_Q       8'h15
`define KEY_W       8'h1d
`define KEY_F1      8'h05
`define KEY_F2      8'h06
`define KEY_1       8'h16
`define KEY_2       8'h1e
`define KEY_ESC     8'h76
`define KEY_5       8'h2e
`define KEY_6       8'h36

// HDMI aspect ratios
`define ARX_WIDE  8'd16
`define ARY_WIDE  8'd9
`define ARX_LAND  8'd4
`define ARY_LAND  8'd3
`define ARX_PORT  8'd3
`define ARY_PORT  8'd4

`endif
